//--- rtl/zxuno_pkg.sv
package zxuno_pkg;

   // -----------------------------------------------
   // Bus structs
   // -----------------------------------------------

   // CPU side of the I/O bus, one copy fanned to every block
   typedef struct packed {
      logic [15:0] a;         // Full I/O address A15..A0
      logic        iorq_n;
      logic        rd_n;
      logic        wr_n;
      logic [7:0]  din;       // Data out of the CPU
   } cpu_bus_t;

   // Register space access from the indirect port pair
   typedef struct packed {
      logic [7:0] addr;             // Current register number
      logic       regrd;            // One cycle per data port read
      logic       regwr;            // One cycle per data port write
      logic       regaddr_changed;  // New value in the address register
   } reg_access_t;

   // One read source toward the CPU input data bus
   typedef struct packed {
      logic [7:0] dout;
      logic       oe_n;       // Low drives the bus
   } rd_src_t;

   // -----------------------------------------------
   // Register numbers and ports
   // -----------------------------------------------
   localparam logic [7:0]  REG_JOYCONF = 8'h06;
   localparam logic [7:0]  REG_SCRATCH = 8'hFE;
   localparam logic [7:0]  REG_COREID  = 8'hFF;

   localparam logic [15:0] DEF_ADDR_PORT     = 16'hFC3B;
   localparam logic [15:0] DEF_DATA_PORT     = 16'hFD3B;
   localparam logic [7:0]  DEF_KEMPSTON_PORT = 8'h1F;   // Low byte only

   // Read sources, lowest index wins the bus
   localparam int N_RD_SRC     = 5;
   localparam int SRC_ADDR     = 0;
   localparam int SRC_SCRATCH  = 1;
   localparam int SRC_COREID   = 2;
   localparam int SRC_JOYCONF  = 3;
   localparam int SRC_KEMPSTON = 4;

   localparam logic [7:0] FLOATING_BUS = 8'hFF;   // Pulled-up idle bus

   // I/O read cycle in progress
   function automatic logic io_rd(cpu_bus_t b);
      return !b.iorq_n && !b.rd_n;
   endfunction

   // I/O write cycle in progress
   function automatic logic io_wr(cpu_bus_t b);
      return !b.iorq_n && !b.wr_n;
   endfunction

endpackage

//--- rtl/zxuno_regs.sv
`timescale 1ns/1ps

module zxuno_regs #(
   parameter logic [15:0] ADDR_PORT = zxuno_pkg::DEF_ADDR_PORT,
   parameter logic [15:0] DATA_PORT = zxuno_pkg::DEF_DATA_PORT
) (
   input  logic                   clk,
   input  logic                   rst_n,
   input  zxuno_pkg::cpu_bus_t    bus,
   output zxuno_pkg::reg_access_t racc,
   output zxuno_pkg::rd_src_t     addr_rd
);
   import zxuno_pkg::*;

   logic       addr_port_wr;   // Write to the address port
   logic       addr_port_rd;
   logic       data_port_wr;
   logic       data_port_rd;
   logic       addr_port_wr_q; // Previous cycle, for edge detect
   logic       data_port_wr_q;
   logic       data_port_rd_q;
   logic [7:0] addr_q;         // Register address
   logic       regrd_q;
   logic       regwr_q;
   logic       changed_q;

   // Port decode on all 16 address bits
   assign addr_port_wr = io_wr(bus) && (bus.a == ADDR_PORT);
   assign addr_port_rd = io_rd(bus) && (bus.a == ADDR_PORT);
   assign data_port_wr = io_wr(bus) && (bus.a == DATA_PORT);
   assign data_port_rd = io_rd(bus) && (bus.a == DATA_PORT);

   // -----------------------------------------------
   // Strobes and address register
   // -----------------------------------------------
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         addr_port_wr_q <= 1'b0;
         data_port_wr_q <= 1'b0;
         data_port_rd_q <= 1'b0;
         addr_q         <= 8'h00;
         regrd_q        <= 1'b0;
         regwr_q        <= 1'b0;
         changed_q      <= 1'b0;
      end else begin
         addr_port_wr_q <= addr_port_wr;
         data_port_wr_q <= data_port_wr;
         data_port_rd_q <= data_port_rd;
         // One pulse per bus cycle however long it is held
         changed_q <= addr_port_wr && !addr_port_wr_q;
         regwr_q   <= data_port_wr && !data_port_wr_q;
         regrd_q   <= data_port_rd && !data_port_rd_q;
         if (addr_port_wr && !addr_port_wr_q) begin
            addr_q <= bus.din;   // Visible with the changed pulse
         end
      end
   end

   assign racc.addr            = addr_q;
   assign racc.regrd           = regrd_q;
   assign racc.regwr           = regwr_q;
   assign racc.regaddr_changed = changed_q;

   // Address readback
   assign addr_rd.dout = addr_q;
   assign addr_rd.oe_n = !addr_port_rd;

   // Data port read and write are separate bus cycles
   a_rdwr_excl: assert property (@(posedge clk) disable iff (!rst_n)
      !(racc.regrd && racc.regwr));

endmodule

//--- rtl/scratch_register.sv
`timescale 1ns/1ps

module scratch_register #(
   parameter logic [15:0] DATA_PORT = zxuno_pkg::DEF_DATA_PORT
) (
   input  logic                   clk,
   input  logic                   rst_n,
   input  zxuno_pkg::reg_access_t racc,
   input  zxuno_pkg::cpu_bus_t    bus,
   output zxuno_pkg::rd_src_t     rd
);
   import zxuno_pkg::*;

   logic [7:0] scratch_q;   // General purpose byte
   logic       sel;         // Register selected
   logic       sel_rd;

   assign sel    = (racc.addr == REG_SCRATCH);
   assign sel_rd = io_rd(bus) && (bus.a == DATA_PORT) && sel;

   // Capture on the write strobe
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         scratch_q <= 8'h00;
      end else if (racc.regwr && sel) begin
         scratch_q <= bus.din;   // din still held by the bus cycle
      end
   end

   // Drive the bus only during our own read
   assign rd.dout = scratch_q;
   assign rd.oe_n = !sel_rd;

endmodule

//--- rtl/coreid.sv
`timescale 1ns/1ps

module coreid #(
   parameter logic [15:0]             DATA_PORT  = zxuno_pkg::DEF_DATA_PORT,
   parameter int                      COREID_LEN = 4,
   parameter logic [8*COREID_LEN-1:0] COREID     = "T1.0"
) (
   input  logic                   clk,
   input  logic                   rst_n,
   input  zxuno_pkg::reg_access_t racc,
   input  zxuno_pkg::cpu_bus_t    bus,
   output zxuno_pkg::rd_src_t     rd
);
   import zxuno_pkg::*;

   localparam int IDX_W = $clog2(COREID_LEN + 1);   // Room for the end state

   logic [IDX_W-1:0] idx;         // Next byte to hand out
   logic [7:0]       cur_byte;
   logic [7:0]       held_byte;   // Byte already consumed by this read
   logic             consumed;
   logic             sel_rd;
   logic             take;        // Strobe for one consumed byte

   assign sel_rd = io_rd(bus) && (bus.a == DATA_PORT) && (racc.addr == REG_COREID);
   assign take   = racc.regrd && (racc.addr == REG_COREID);

   // Byte select, first character sits in the top byte
   always_comb begin
      cur_byte = 8'h00;   // Past the end of the string
      for (int i = 0; i < COREID_LEN; i++) begin
         if (idx == IDX_W'(i)) begin
            cur_byte = COREID[8*(COREID_LEN-1-i) +: 8];
         end
      end
   end

   // -----------------------------------------------
   // Index and read hold
   // -----------------------------------------------
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         idx      <= '0;
         consumed <= 1'b0;
      end else begin
         if (racc.regaddr_changed) begin
            idx <= '0;   // Restart the string
         end else if (take && idx != IDX_W'(COREID_LEN)) begin
            idx <= idx + 1'b1;   // Saturates at the end
         end
         if (take) begin
            consumed <= 1'b1;
         end else if (!sel_rd) begin
            consumed <= 1'b0;   // Bus cycle over
         end
      end
   end

   always_ff @(posedge clk) begin
      if (take) begin
         held_byte <= cur_byte;
      end
   end

   // Keep the presented byte stable until the read ends
   assign rd.dout = consumed ? held_byte : cur_byte;
   assign rd.oe_n = !sel_rd;

   a_idx_range: assert property (@(posedge clk) disable iff (!rst_n)
      idx <= IDX_W'(COREID_LEN));

endmodule

//--- rtl/kempston_joystick.sv
`timescale 1ns/1ps

module kempston_joystick #(
   parameter logic [15:0] DATA_PORT     = zxuno_pkg::DEF_DATA_PORT,
   parameter logic [7:0]  KEMPSTON_PORT = zxuno_pkg::DEF_KEMPSTON_PORT
) (
   input  logic                   clk,
   input  logic                   rst_n,
   input  zxuno_pkg::reg_access_t racc,
   input  zxuno_pkg::cpu_bus_t    bus,
   input  logic [4:0]             db9,   // fire up down left right, low active
   output zxuno_pkg::rd_src_t     conf_rd,
   output zxuno_pkg::rd_src_t     joy_rd,
   output logic                   kempston_enabled
);
   import zxuno_pkg::*;

   logic [7:0] joyconf_q;   // Joystick configuration
   logic       conf_sel;
   logic       conf_sel_rd;
   logic       kemp_rd;     // Read of the Kempston port

   assign conf_sel    = (racc.addr == REG_JOYCONF);
   assign conf_sel_rd = io_rd(bus) && (bus.a == DATA_PORT) && conf_sel;
   assign kemp_rd     = io_rd(bus) && (bus.a[7:0] == KEMPSTON_PORT);   // Partial decode

   // -----------------------------------------------
   // Configuration register
   // -----------------------------------------------
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         joyconf_q <= 8'h00;   // Kempston off
      end else if (racc.regwr && conf_sel) begin
         joyconf_q <= bus.din;
      end
   end

   assign kempston_enabled = joyconf_q[0];

   // Readback at REG_JOYCONF
   assign conf_rd.dout = joyconf_q;
   assign conf_rd.oe_n = !conf_sel_rd;

   // Kempston layout 000FUDLR, active high
   assign joy_rd.dout = {3'b000, ~db9};
   assign joy_rd.oe_n = !(kemp_rd && kempston_enabled);   // Floats when disabled

endmodule

//--- rtl/cpu_data_mux.sv
`timescale 1ns/1ps

module cpu_data_mux (
   input  logic               clk,                        // Assertion sampling only
   input  zxuno_pkg::rd_src_t src [zxuno_pkg::N_RD_SRC],
   output logic [7:0]         cpudin
);
   import zxuno_pkg::*;

   logic [N_RD_SRC-1:0] drv;   // Sources driving the bus

   // Priority merge, index 0 wins
   always_comb begin
      cpudin = FLOATING_BUS;   // Nobody drives
      for (int i = N_RD_SRC - 1; i >= 0; i--) begin
         if (!src[i].oe_n) begin
            cpudin = src[i].dout;
         end
      end
   end

   always_comb begin
      for (int i = 0; i < N_RD_SRC; i++) begin
         drv[i] = !src[i].oe_n;
      end
   end

   // Decoders of all blocks must not overlap
   a_one_driver: assert property (@(posedge clk) $countones(drv) <= 1);

endmodule

//--- rtl/zxuno_io.sv
`timescale 1ns/1ps

module zxuno_io #(
   parameter logic [15:0]             ADDR_PORT     = zxuno_pkg::DEF_ADDR_PORT,
   parameter logic [15:0]             DATA_PORT     = zxuno_pkg::DEF_DATA_PORT,
   parameter logic [7:0]              KEMPSTON_PORT = zxuno_pkg::DEF_KEMPSTON_PORT,
   parameter int                      COREID_LEN    = 4,
   parameter logic [8*COREID_LEN-1:0] COREID        = "T1.0"
) (
   input  logic        clk,        // 28 MHz system clock
   input  logic        rst_n,
   // CPU bus
   input  logic [15:0] a,
   input  logic        iorq_n,
   input  logic        rd_n,
   input  logic        wr_n,
   input  logic [7:0]  din,
   // DB9 joystick, low active
   input  logic        joyup,
   input  logic        joydown,
   input  logic        joyleft,
   input  logic        joyright,
   input  logic        joyfire,
   output logic [7:0]  cpudin,
   output logic [7:0]  user_regaddr,
   output logic        kempston_enabled
);
   import zxuno_pkg::*;

   cpu_bus_t    bus;
   reg_access_t racc;
   rd_src_t     src [N_RD_SRC];   // Read sources in priority order

   assign bus = '{a: a, iorq_n: iorq_n, rd_n: rd_n, wr_n: wr_n, din: din};
   assign user_regaddr = racc.addr;

   // -----------------------------------------------
   // Port decode and register address
   // -----------------------------------------------
   zxuno_regs #(.ADDR_PORT(ADDR_PORT), .DATA_PORT(DATA_PORT)) u_regs (
      .clk    (clk),
      .rst_n  (rst_n),
      .bus    (bus),
      .racc   (racc),
      .addr_rd(src[SRC_ADDR])
   );

   scratch_register #(.DATA_PORT(DATA_PORT)) u_scratch (
      .clk  (clk),
      .rst_n(rst_n),
      .racc (racc),
      .bus  (bus),
      .rd   (src[SRC_SCRATCH])
   );

   coreid #(
      .DATA_PORT (DATA_PORT),
      .COREID_LEN(COREID_LEN),
      .COREID    (COREID)
   ) u_coreid (
      .clk  (clk),
      .rst_n(rst_n),
      .racc (racc),
      .bus  (bus),
      .rd   (src[SRC_COREID])
   );

   kempston_joystick #(.DATA_PORT(DATA_PORT), .KEMPSTON_PORT(KEMPSTON_PORT)) u_joy (
      .clk             (clk),
      .rst_n           (rst_n),
      .racc            (racc),
      .bus             (bus),
      .db9             ({joyfire, joyup, joydown, joyleft, joyright}),
      .conf_rd         (src[SRC_JOYCONF]),
      .joy_rd          (src[SRC_KEMPSTON]),
      .kempston_enabled(kempston_enabled)
   );

   // Merge onto the CPU input bus
   cpu_data_mux u_mux (
      .clk   (clk),
      .src   (src),
      .cpudin(cpudin)
   );

endmodule

//--- dv/tb_zxuno_io.sv
`timescale 1ns/1ps

module tb_zxuno_io;
   import zxuno_pkg::*;

   localparam int CLK_NS = 10;

   // One bus access with everything expected after it
   typedef struct packed {
      logic        is_wr;
      logic [15:0] port;
      logic [7:0]  data;
      logic [4:0]  db9;        // fire up down left right, low active
      logic [7:0]  exp_dout;   // Read data, unused on writes
      logic [7:0]  exp_addr;   // Register address after the access
      logic        exp_kemp;
   } stim_t;

   logic        clk;
   logic        rst_n;
   logic [15:0] a;
   logic        iorq_n;
   logic        rd_n;
   logic        wr_n;
   logic [7:0]  din;
   logic        joyup;
   logic        joydown;
   logic        joyleft;
   logic        joyright;
   logic        joyfire;
   logic [7:0]  cpudin;
   logic [7:0]  user_regaddr;
   logic        kempston_enabled;

   stim_t      table_q [$];
   bit         table_ready = 1'b0;
   int         byte_errors = 0;
   int         bit_errors  = 0;
   int         n_checks    = 0;

   // Reference model state
   logic [7:0] m_addr    = 8'h00;
   logic [7:0] m_scratch = 8'h00;
   logic [7:0] m_conf    = 8'h00;
   int         m_idx     = 0;
   logic [7:0] id_bytes [4] = '{8'h54, 8'h31, 8'h2E, 8'h30};   // "T1.0"

   zxuno_io u_dut (
      .clk             (clk),
      .rst_n           (rst_n),
      .a               (a),
      .iorq_n          (iorq_n),
      .rd_n            (rd_n),
      .wr_n            (wr_n),
      .din             (din),
      .joyup           (joyup),
      .joydown         (joydown),
      .joyleft         (joyleft),
      .joyright        (joyright),
      .joyfire         (joyfire),
      .cpudin          (cpudin),
      .user_regaddr    (user_regaddr),
      .kempston_enabled(kempston_enabled)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_NS / 2) clk = ~clk;
   end

   // --------------------------------------------------
   // Table building, model updated as entries go in
   // --------------------------------------------------
   task automatic push_write(input logic [15:0] port, input logic [7:0] data);
      stim_t s;
      if (port == DEF_ADDR_PORT) begin
         m_addr = data;
         m_idx  = 0;   // New address restarts the id string
      end else if (port == DEF_DATA_PORT) begin
         if (m_addr == REG_SCRATCH) m_scratch = data;
         if (m_addr == REG_JOYCONF) m_conf = data;
      end
      s = '{is_wr: 1'b1, port: port, data: data, db9: 5'h1F, exp_dout: 8'h00,
            exp_addr: m_addr, exp_kemp: m_conf[0]};
      table_q.push_back(s);
   endtask

   task automatic expect_read(input logic [15:0] port, input logic [4:0] db9);
      stim_t      s;
      logic [7:0] exp;
      exp = FLOATING_BUS;   // Nobody answers
      if (port == DEF_ADDR_PORT) begin
         exp = m_addr;
      end else if (port == DEF_DATA_PORT) begin
         if (m_addr == REG_SCRATCH) begin
            exp = m_scratch;
         end else if (m_addr == REG_JOYCONF) begin
            exp = m_conf;
         end else if (m_addr == REG_COREID) begin
            exp = (m_idx < 4) ? id_bytes[m_idx] : 8'h00;
            if (m_idx < 4) m_idx++;   // Saturates past the end
         end
      end else if (port[7:0] == DEF_KEMPSTON_PORT && m_conf[0]) begin
         exp = {3'b000, ~db9};   // Active high FUDLR
      end
      s = '{is_wr: 1'b0, port: port, data: 8'h00, db9: db9, exp_dout: exp,
            exp_addr: m_addr, exp_kemp: m_conf[0]};
      table_q.push_back(s);
   endtask

   task automatic build_table();
      logic [7:0] v;
      // After reset
      expect_read(DEF_ADDR_PORT, 5'h1F);
      expect_read(16'h1234, 5'h1F);
      expect_read(16'h001F, 5'h0A);      // Kempston still off
      expect_read(DEF_DATA_PORT, 5'h1F);  // Register 0x00 unmapped
      // Register address
      push_write(DEF_ADDR_PORT, 8'h5A);
      expect_read(DEF_ADDR_PORT, 5'h1F);
      push_write(DEF_ADDR_PORT, 8'hA5);
      expect_read(DEF_ADDR_PORT, 5'h1F);
      // Scratch with random bytes
      push_write(DEF_ADDR_PORT, REG_SCRATCH);
      for (int i = 0; i < 4; i++) begin
         v = 8'($urandom);
         push_write(DEF_DATA_PORT, v);
         expect_read(DEF_DATA_PORT, 5'h1F);
      end
      push_write(DEF_ADDR_PORT, 8'h10);   // Away and back
      expect_read(DEF_DATA_PORT, 5'h1F);
      push_write(DEF_ADDR_PORT, REG_SCRATCH);
      expect_read(DEF_DATA_PORT, 5'h1F);
      // Core id, past the end, then restart
      push_write(DEF_ADDR_PORT, REG_COREID);
      repeat (6) expect_read(DEF_DATA_PORT, 5'h1F);
      push_write(DEF_ADDR_PORT, REG_COREID);
      repeat (2) expect_read(DEF_DATA_PORT, 5'h1F);
      // Kempston
      expect_read(16'h001F, 5'h15);
      push_write(DEF_ADDR_PORT, REG_JOYCONF);
      push_write(DEF_DATA_PORT, 8'h01);
      expect_read(DEF_DATA_PORT, 5'h1F);  // Config readback
      expect_read(16'h001F, 5'h1F);       // Nothing pressed
      expect_read(16'h001F, 5'h0F);       // Fire
      expect_read(16'h001F, 5'h15);
      expect_read(16'hAB1F, 5'h0A);       // Low byte decode only
      expect_read(16'h001F, 5'h00);
      push_write(DEF_DATA_PORT, 8'h00);
      expect_read(16'h001F, 5'h00);       // Off again
   endtask

   // --------------------------------------------------
   // Bus tasks, called and returning on a falling edge
   // --------------------------------------------------
   task automatic io_write(input logic [15:0] port, input logic [7:0] data);
      a      = port;
      din    = data;
      iorq_n = 1'b0;
      wr_n   = 1'b0;
      repeat (3) @(negedge clk);
      iorq_n = 1'b1;
      wr_n   = 1'b1;
      a      = 16'h0000;
      @(negedge clk);   // Idle cycle
   endtask

   task automatic io_read(input logic [15:0] port, output logic [7:0] value);
      a      = port;
      iorq_n = 1'b0;
      rd_n   = 1'b0;
      repeat (3) @(negedge clk);
      value  = cpudin;   // Last held cycle
      iorq_n = 1'b1;
      rd_n   = 1'b1;
      a      = 16'h0000;
      @(negedge clk);
   endtask

   task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp,
                             input int entry);
      n_checks++;
      if (got !== exp) begin
         byte_errors++;
         $display("[ERROR] %s: got 0x%02h expected 0x%02h (entry %0d)", name, got, exp, entry);
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp,
                            input int entry);
      n_checks++;
      if (got !== exp) begin
         bit_errors++;
         $display("[ERROR] %s: got 0x%0h expected 0x%0h (entry %0d)", name, got, exp, entry);
      end
   endtask

   // Watchdog sized from the table
   initial begin
      int wd_ns;
      wait (table_ready);
      wd_ns = table_q.size() * 4 * CLK_NS + 200;
      #(wd_ns);
      $display("Watchdog expired after %0d ns, bus sequence did not complete", wd_ns);
      $display("TESTS FAILED");
      $finish;
   end

   initial begin
      stim_t      s;
      logic [7:0] got;
      void'($urandom(6));
      rst_n    = 1'b0;
      a        = 16'h0000;
      iorq_n   = 1'b1;
      rd_n     = 1'b1;
      wr_n     = 1'b1;
      din      = 8'h00;
      {joyfire, joyup, joydown, joyleft, joyright} = 5'h1F;   // Released
      build_table();
      table_ready = 1'b1;
      repeat (5) @(negedge clk);
      rst_n = 1'b1;
      foreach (table_q[i]) begin
         s = table_q[i];
         {joyfire, joyup, joydown, joyleft, joyright} = s.db9;
         if (s.is_wr) begin
            io_write(s.port, s.data);
         end else begin
            io_read(s.port, got);
            check_byte("cpudin", got, s.exp_dout, i);
         end
         check_byte("user_regaddr", user_regaddr, s.exp_addr, i);
         check_bit("kempston_enabled", kempston_enabled, s.exp_kemp, i);
      end
      $display("Checks %0d, byte errors %0d, bit errors %0d", n_checks, byte_errors, bit_errors);
      if (byte_errors + bit_errors == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule

//--- filelist.f
rtl/zxuno_pkg.sv
rtl/zxuno_regs.sv
rtl/scratch_register.sv
rtl/coreid.sv
rtl/kempston_joystick.sv
rtl/cpu_data_mux.sv
rtl/zxuno_io.sv
dv/tb_zxuno_io.sv

//--- Makefile
# Verilator flow for the zxuno_io register subsystem

VERILATOR  ?= verilator
FILELIST   ?= filelist.f
TOP        ?= tb_zxuno_io
RTL_TOP    ?= zxuno_io
OBJ_DIR    ?= obj_dir
LINT_FLAGS ?= --lint-only --timing
SIM_FLAGS  ?= --binary --timing --assert
PASS_MSG   ?= TESTS PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

$(OBJ_DIR)/V$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -o V$(TOP)

sim: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
